/* trace_pkg.sv */
// trace_pkg: frame byte and timestamp types, interrupt event struct, record and COBS constants
`default_nettype none

package trace_pkg;

  // one byte on the trace path
  typedef logic [7:0] trace_byte_t;

  // free-running cycle stamp
  typedef logic [31:0] trace_ts_t;

  // strobe payload from the interrupt controller
  typedef struct packed {
    logic [7:0] id;
    logic [7:0] level;
    logic       tail_chain;
  } trace_event_t;

  // raw record layout, one byte per slot
  localparam int RecordBytes = 7;
  localparam int RecIdOffs = 0;
  localparam int RecLevelOffs = 1;
  localparam int RecFlagsOffs = 2;
  localparam int RecTsOffs = 3;

  // stamp bytes, least significant first
  localparam int TsBytes = $bits(trace_ts_t) / 8;

  // bit position of tail_chain inside the flags byte
  localparam int FlagTailChain = 0;

  // code byte + encoded record + delimiter
  localparam int FrameBytes = RecordBytes + 2;

  // frame delimiter, never appears inside an encoded frame
  localparam trace_byte_t CobsDelim = 8'h00;

endpackage

`default_nettype wire

/* trace_encoder.sv */
// trace_encoder: cycle timer, event capture into a 7-byte record, COBS frame byte emitter
`default_nettype none

module trace_encoder (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   event_valid_i,
  input  trace_pkg::trace_event_t event_i,
  input  logic                   full_i,
  output logic                   wr_en_o,
  output trace_pkg::trace_byte_t wr_data_o,
  output logic                   busy_o
);
  import trace_pkg::*;

  localparam int IdxW = $clog2(FrameBytes);

  // run codes for every start slot, slot RecordBytes is the empty tail run
  typedef trace_byte_t [RecordBytes:0] code_vec_t;
  typedef trace_byte_t [RecordBytes-1:0] record_t;

  trace_ts_t        ts_q;
  logic             busy_q;
  logic [IdxW-1:0]  idx_q;
  logic [IdxW-1:0]  rec_idx;
  record_t          rec_q;
  code_vec_t        codes;
  trace_byte_t      frame_byte;
  trace_byte_t      flags;
  logic             accept;

  // distance from each slot to the next zero, counted as COBS codes
  function automatic code_vec_t run_codes(input record_t rec);
    code_vec_t c;
    c[RecordBytes] = 8'd1;
    for (int s = RecordBytes - 1; s >= 0; s--) begin
      if (rec[s] == CobsDelim) begin
        c[s] = 8'd1;
      end else begin
        c[s] = c[s+1] + 8'd1;
      end
    end
    return c;
  endfunction

  assign accept = event_valid_i && !busy_q;
  assign busy_o = busy_q;

  // free-running stamp, 0 in the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ts_q <= '0;
    end else begin
      ts_q <= ts_q + 1'b1;
    end
  end

  always_comb begin
    flags = '0;
    flags[FlagTailChain] = event_i.tail_chain;
  end

  // record capture on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rec_q[RecIdOffs]    <= event_i.id;
      rec_q[RecLevelOffs] <= event_i.level;
      rec_q[RecFlagsOffs] <= flags;
      for (int b = 0; b < TsBytes; b++) begin
        rec_q[RecTsOffs+b] <= ts_q[8*b +: 8];
      end
    end
  end

  // frame walk control
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (wr_en_o) begin
      if (idx_q == IdxW'(FrameBytes - 1)) begin
        busy_q <= 1'b0;
        idx_q  <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  assign codes   = run_codes(rec_q);
  assign rec_idx = idx_q - 1'b1;

  // slot 0 is the leading code, zeros in the record become the code of the next run
  always_comb begin
    if (idx_q == '0) begin
      frame_byte = codes[0];
    end else if (idx_q == IdxW'(FrameBytes - 1)) begin
      frame_byte = CobsDelim;
    end else if (rec_q[rec_idx] != CobsDelim) begin
      frame_byte = rec_q[rec_idx];
    end else begin
      frame_byte = codes[idx_q];
    end
  end

  // stall while the FIFO is full
  assign wr_en_o   = busy_q && !full_i;
  assign wr_data_o = frame_byte;

endmodule

`default_nettype wire

/* trace_fifo.sv */
// trace_fifo: circular byte FIFO with show-ahead read, occupancy count, full and not-empty levels
`default_nettype none

module trace_fifo #(
  parameter int FifoDepth = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   wr_en_i,
  input  trace_pkg::trace_byte_t wr_data_i,
  input  logic                   ack_i,
  output trace_pkg::trace_byte_t rd_data_o,
  output logic                   have_next_o,
  output logic                   full_o
);
  import trace_pkg::*;

  localparam int AddrW = $clog2(FifoDepth);

  trace_byte_t      mem_q [FifoDepth];
  logic [AddrW-1:0] wr_ptr_q;
  logic [AddrW-1:0] rd_ptr_q;
  logic [AddrW:0]   count_q;
  logic             do_wr;
  logic             do_rd;

  assign have_next_o = count_q != '0;
  assign full_o      = count_q == (AddrW + 1)'(FifoDepth);

  // guard against overrun and underrun
  assign do_wr = wr_en_i && !full_o;
  assign do_rd = ack_i && have_next_o;

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // push and pop together keep the count
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // show-ahead, oldest byte
  assign rd_data_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

/* uart_tx.sv */
// uart_tx: 8N1 serializer that pops bytes from the FIFO, with bit-time prescaler
`default_nettype none

module uart_tx #(
  parameter int ClksPerBit = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   have_next_i,
  input  trace_pkg::trace_byte_t data_i,
  output logic                   ack_o,
  output logic                   tx_o
);

  // start + 8 data + stop
  localparam int FrameBits = 10;
  localparam int PrescW = $clog2(ClksPerBit);
  localparam int BitCntW = $clog2(FrameBits);

  logic                 active_q;
  logic [FrameBits-1:0] shift_q;
  logic [PrescW-1:0]    presc_q;
  logic [BitCntW-1:0]   bit_cnt_q;
  logic                 bit_done;

  // pop only from idle
  assign ack_o    = !active_q && have_next_i;
  assign bit_done = presc_q == PrescW'(ClksPerBit - 1);

  // line idles high, shift register fills with ones
  assign tx_o = shift_q[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q  <= 1'b0;
      shift_q   <= '1;
      presc_q   <= '0;
      bit_cnt_q <= '0;
    end else if (ack_o) begin
      active_q  <= 1'b1;
      shift_q   <= {1'b1, data_i, 1'b0};
      presc_q   <= '0;
      bit_cnt_q <= '0;
    end else if (active_q) begin
      if (bit_done) begin
        presc_q <= '0;
        shift_q <= {1'b1, shift_q[FrameBits-1:1]};
        // stop bit done, back to idle
        if (bit_cnt_q == BitCntW'(FrameBits - 1)) begin
          active_q  <= 1'b0;
          bit_cnt_q <= '0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else begin
        presc_q <= presc_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* trace_top.sv */
// trace_top: interrupt trace path, encoder into byte FIFO into UART transmitter
`default_nettype none

module trace_top #(
  parameter int ClksPerBit = 8,
  parameter int FifoDepth  = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    event_valid_i,
  input  trace_pkg::trace_event_t event_i,
  output logic                    busy_o,
  output logic                    tx_o
);
  import trace_pkg::*;

  // encoder to FIFO
  logic        enc_wr_en;
  trace_byte_t enc_wr_data;
  logic        fifo_full;

  // FIFO to UART
  trace_byte_t fifo_rd_data;
  logic        fifo_have_next;
  logic        uart_ack;

  trace_encoder i_trace_encoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .event_valid_i(event_valid_i),
    .event_i      (event_i),
    .full_i       (fifo_full),
    .wr_en_o      (enc_wr_en),
    .wr_data_o    (enc_wr_data),
    .busy_o       (busy_o)
  );

  trace_fifo #(
    .FifoDepth(FifoDepth)
  ) i_trace_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_en_i    (enc_wr_en),
    .wr_data_i  (enc_wr_data),
    .ack_i      (uart_ack),
    .rd_data_o  (fifo_rd_data),
    .have_next_o(fifo_have_next),
    .full_o     (fifo_full)
  );

  uart_tx #(
    .ClksPerBit(ClksPerBit)
  ) i_uart_tx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .have_next_i(fifo_have_next),
    .data_i     (fifo_rd_data),
    .ack_o      (uart_ack),
    .tx_o       (tx_o)
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// tb_clk_gen: testbench clock source and power-on reset
`default_nettype none

module tb_clk_gen #(
  parameter int HalfPeriod  = 5,
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // release just after an edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* trace_properties.sv */
// trace_properties: FIFO overrun, underrun and occupancy assertions, bound into trace_fifo
`default_nettype none

module trace_properties #(
  parameter int FifoDepth = 16
) (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         wr_en_i,
  input logic                         ack_i,
  input logic                         have_next_i,
  input logic                         full_i,
  input logic [$clog2(FifoDepth):0]   count_i
);

  // encoder must stall on full
  a_no_write_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) full_i |-> !wr_en_i
  ) else $error("write strobe while FIFO full");

  // UART pops only a waiting byte
  a_no_ack_when_empty : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !have_next_i |-> !ack_i
  ) else $error("ack while FIFO empty");

  a_count_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) count_i <= ($clog2(FifoDepth) + 1)'(FifoDepth)
  ) else $error("FIFO occupancy above depth");

endmodule

bind trace_fifo trace_properties #(
  .FifoDepth(FifoDepth)
) i_trace_properties (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .wr_en_i    (wr_en_i),
  .ack_i      (ack_i),
  .have_next_i(have_next_o),
  .full_i     (full_o),
  .count_i    (count_q)
);

`default_nettype wire

/* trace_tb.sv */
// directed tests, UART receiver model, COBS reference model, checks and watchdog
`default_nettype none

module trace_tb;
  import trace_pkg::*;

  localparam int ClksPerBit = 8;
  localparam int FifoDepth = 16;
  localparam int ByteCycles = 10 * ClksPerBit;
  localparam int FrameCycles = FrameBytes * ByteCycles;
  // six frames plus one extra frame time of silence in the drop test
  localparam int TotalFrames = 7;
  localparam int WatchdogCycles = TotalFrames * FrameCycles + 2000;
  localparam int QuietCycles = 2 * ByteCycles + ClksPerBit;

  typedef trace_byte_t [RecordBytes-1:0] record_t;
  typedef trace_byte_t [FrameBytes-1:0] frame_t;

  logic         clk;
  logic         rst_n;
  logic         event_valid;
  trace_event_t ev;
  logic         busy;
  logic         tx;

  trace_ts_t    cycle_q;
  logic [31:0]  lfsr_q;
  int           full_cycles;
  trace_byte_t  rx_q[$];

  tb_clk_gen i_tb_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  trace_top #(
    .ClksPerBit(ClksPerBit),
    .FifoDepth (FifoDepth)
  ) i_trace_top (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .event_valid_i(event_valid),
    .event_i      (ev),
    .busy_o       (busy),
    .tx_o         (tx)
  );

  // mirrors the DUT timer that reads 0 in the first cycle out of reset
  always @(posedge clk) begin
    if (!rst_n) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1;
    end
  end

  // FIFO full cycles counted on the falling edge
  always @(negedge clk) begin
    if (i_trace_top.fifo_full === 1'b1) begin
      full_cycles <= full_cycles + 1;
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("error at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v[i] = lfsr_q[0];
    end
  endtask

  task automatic random_event(output trace_event_t e);
    logic [31:0] v;
    take_bits(8, v);
    e.id = v[7:0];
    take_bits(8, v);
    e.level = v[7:0];
    take_bits(1, v);
    e.tail_chain = v[0];
  endtask

  // id, level, flags, then stamp LSB first
  function automatic record_t make_record(input trace_event_t e, input trace_ts_t ts);
    record_t r;
    r[0] = e.id;
    r[1] = e.level;
    r[2] = {7'd0, e.tail_chain};
    for (int b = 0; b < 4; b++) begin
      r[3+b] = ts[8*b +: 8];
    end
    return r;
  endfunction

  // plain COBS without 0xff block splits for a 7-byte record
  function automatic frame_t cobs_frame(input record_t rec);
    frame_t      f;
    int          code_pos;
    int          o;
    trace_byte_t code;
    f = '0;
    code_pos = 0;
    o = 1;
    code = 8'd1;
    for (int i = 0; i < RecordBytes; i++) begin
      if (rec[i] == 8'h00) begin
        f[code_pos] = code;
        code_pos = o;
        code = 8'd1;
      end else begin
        f[o] = rec[i];
        code = code + 8'd1;
      end
      o++;
    end
    f[code_pos] = code;
    f[FrameBytes-1] = 8'h00;
    return f;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // one-cycle strobe stamped with the timer value of that cycle
  task automatic send_event(input trace_event_t e, output trace_ts_t stamp);
    event_valid = 1'b1;
    ev = e;
    stamp = cycle_q;
    step();
    event_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy !== 1'b0) begin
      step();
      n++;
      if (n > 2 * FrameCycles) begin
        report_failure("encoder stayed busy far longer than a frame takes");
      end
    end
  endtask

  task automatic wait_rx(input int n);
    int c;
    c = 0;
    while (rx_q.size() < n) begin
      step();
      c++;
      if (c > (n + 2) * (ByteCycles + ClksPerBit)) begin
        report_failure($sformatf("only %0d of %0d bytes arrived on the line", rx_q.size(), n));
      end
    end
  endtask

  task automatic check_frame(input trace_event_t e, input trace_ts_t stamp);
    frame_t      exp;
    trace_byte_t got;
    exp = cobs_frame(make_record(e, stamp));
    for (int i = 0; i < FrameBytes; i++) begin
      got = rx_q.pop_front();
      check_eq($sformatf("frame byte %0d", i), 32'(got), 32'(exp[i]));
    end
  endtask

  task automatic check_quiet(input int cycles);
    repeat (cycles) step();
    check_eq("extra received bytes", 32'(rx_q.size()), 32'd0);
  endtask

  task automatic test_idle();
    repeat (50) begin
      step();
      check_eq("tx_o", 32'(tx), 32'd1);
      check_eq("busy_o", 32'(busy), 32'd0);
    end
  endtask

  task automatic test_single();
    trace_event_t e;
    trace_ts_t    s;
    random_event(e);
    send_event(e, s);
    wait_rx(FrameBytes);
    check_eq("delimiter", 32'(rx_q[FrameBytes-1]), 32'd0);
    check_frame(e, s);
    check_quiet(QuietCycles);
    wait_idle();
  endtask

  // record starts with three zeros
  task automatic test_zero_fields();
    trace_event_t e;
    trace_ts_t    s;
    e = '0;
    send_event(e, s);
    wait_rx(FrameBytes);
    for (int i = 0; i < FrameBytes - 1; i++) begin
      check_eq($sformatf("nonzero frame byte %0d", i), 32'(rx_q[i] != 8'h00), 32'd1);
    end
    check_frame(e, s);
    check_quiet(QuietCycles);
    wait_idle();
  endtask

  task automatic test_drop_while_busy();
    trace_event_t e1;
    trace_event_t e2;
    trace_ts_t    s1;
    trace_ts_t    s2;
    random_event(e1);
    send_event(e1, s1);
    check_eq("busy_o", 32'(busy), 32'd1);
    random_event(e2);
    send_event(e2, s2);
    wait_rx(FrameBytes);
    check_frame(e1, s1);
    check_quiet(FrameCycles + QuietCycles);
    wait_idle();
  endtask

  // second frame overflows the 16-entry FIFO
  task automatic test_back_pressure();
    trace_event_t e[3];
    trace_ts_t    s[3];
    int           full_before;
    full_before = full_cycles;
    for (int k = 0; k < 3; k++) begin
      wait_idle();
      random_event(e[k]);
      send_event(e[k], s[k]);
    end
    wait_rx(3 * FrameBytes);
    check_eq("fifo full during back-pressure", 32'(full_cycles > full_before), 32'd1);
    for (int k = 0; k < 3; k++) begin
      check_frame(e[k], s[k]);
    end
    check_quiet(QuietCycles);
  endtask

  // sample each bit near its middle on the falling clock
  initial begin : uart_rx
    trace_byte_t b;
    wait (rst_n);
    forever begin
      @(negedge tx);
      repeat (ClksPerBit / 2) @(negedge clk);
      if (tx !== 1'b0) begin
        report_failure("start bit did not stay low on the serial line");
      end
      for (int i = 0; i < 8; i++) begin
        repeat (ClksPerBit) @(negedge clk);
        b[i] = tx;
      end
      repeat (ClksPerBit) @(negedge clk);
      if (tx !== 1'b1) begin
        report_failure("stop bit missing on the serial line");
      end
      rx_q.push_back(b);
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    report_failure($sformatf("run did not finish within %0d cycles", WatchdogCycles));
  end

  initial begin
    event_valid = 1'b0;
    ev = '0;
    lfsr_q = 32'h9667;
    wait (rst_n);
    step();
    test_idle();
    test_single();
    test_zero_fields();
    test_drop_while_busy();
    test_back_pressure();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
trace_pkg.sv
trace_encoder.sv
trace_fifo.sv
uart_tx.sv
trace_top.sv
tb_clk_gen.sv
trace_properties.sv
trace_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := trace_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulation exited with status $$status"; exit 1; fi; \
	if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
